//--- ooo_pkg.sv
package ooo_pkg;

    // Data and pc width.
    localparam int XLEN = 32;

    // Architectural register index width.
    localparam int REG_ADDR_W = 5;

    // Free entries kept back for the dispatch register and the ready delay.
    localparam int ALLOC_MARGIN = 3;

    typedef enum logic [1:0] {
        ENTRY_FREE,
        ENTRY_ISSUED,         // Allocated, result outstanding.
        ENTRY_DONE            // Result written, waiting for the head.
    } rob_state_e;

    // A store/load buffer result never carries a jump target.
    typedef enum logic {
        SRC_ALU,
        SRC_SLB
    } wb_src_e;

endpackage

//--- ooo_if.sv
interface rob_alloc_if import ooo_pkg::*; ();
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic                  ready;    // Registered, one cycle behind occupancy.

    modport source (output valid, pc, rd, input ready);
    modport sink   (input valid, pc, rd, output ready);
endinterface

interface rob_wb_if import ooo_pkg::*; ();
    logic            valid;
    wb_src_e         src;
    logic [XLEN-1:0] pc;           // Tag used to find the entry.
    logic [XLEN-1:0] data;
    logic [XLEN-1:0] target;       // Only meaningful for SRC_ALU.

    modport source (output valid, src, pc, data, target);
    modport sink   (input valid, src, pc, data, target);
endinterface

interface rob_commit_if import ooo_pkg::*; ();
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
    logic                  mispredict;
    logic [XLEN-1:0]       target;

    modport source (output valid, pc, rd, data, mispredict, target);
    modport sink   (input valid, pc, rd, data, mispredict, target);
endinterface

//--- dispatch_stage.sv
module dispatch_stage import ooo_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  dec_valid,
    input  logic [XLEN-1:0]       dec_pc,
    input  logic [REG_ADDR_W-1:0] dec_rd,
    rob_alloc_if.source           alloc
);

    // A strobe seen while ready is low would overrun the margin, so it is dropped.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alloc.valid <= 1'b0;
        end else begin
            alloc.valid <= dec_valid && alloc.ready && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            alloc.pc <= dec_pc;
            alloc.rd <= dec_rd;
        end
    end

endmodule

//--- completion_merge.sv
module completion_merge import ooo_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            alu_valid,
    input  logic [XLEN-1:0] alu_pc,
    input  logic [XLEN-1:0] alu_data,
    input  logic [XLEN-1:0] alu_target,
    input  logic            slb_valid,
    input  logic [XLEN-1:0] slb_pc,
    input  logic [XLEN-1:0] slb_data,
    rob_wb_if.source        wb
);

    logic            park_valid;
    logic [XLEN-1:0] park_pc;
    logic [XLEN-1:0] park_data;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wb.valid   <= 1'b0;
            park_valid <= 1'b0;
        end else begin
            wb.valid <= alu_valid || park_valid || slb_valid;
            if (alu_valid) begin
                park_valid <= park_valid || slb_valid;   // ALU wins the slot.
            end else if (park_valid) begin
                park_valid <= slb_valid;
            end else begin
                park_valid <= 1'b0;
            end
        end
    end

    // Priority: ALU, then the parked result, then a fresh store/load result.
    always_ff @(posedge clk) begin
        if (alu_valid) begin
            wb.src    <= SRC_ALU;
            wb.pc     <= alu_pc;
            wb.data   <= alu_data;
            wb.target <= alu_target;
        end else if (park_valid) begin
            wb.src    <= SRC_SLB;
            wb.pc     <= park_pc;
            wb.data   <= park_data;
            wb.target <= park_pc + 32'd4;
        end else begin
            wb.src    <= SRC_SLB;
            wb.pc     <= slb_pc;
            wb.data   <= slb_data;
            wb.target <= slb_pc + 32'd4;
        end

        if (slb_valid && (alu_valid || park_valid)) begin
            park_pc   <= slb_pc;
            park_data <= slb_data;
        end
    end

endmodule

//--- reorder_buffer.sv
module reorder_buffer import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush,
    rob_alloc_if.sink    alloc,
    rob_wb_if.sink       wb,
    rob_commit_if.source cmt
);

    localparam int PTR_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [XLEN-1:0]       pc_mem     [ROB_DEPTH];
    logic [REG_ADDR_W-1:0] rd_mem     [ROB_DEPTH];
    logic [XLEN-1:0]       data_mem   [ROB_DEPTH];
    logic [XLEN-1:0]       target_mem [ROB_DEPTH];
    rob_state_e            state      [ROB_DEPTH];

    logic [PTR_W-1:0]     head;
    logic [PTR_W-1:0]     tail;
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     count_next;
    logic                 ready_q;
    logic                 squash;       // Mispredict retired, flush not yet seen.
    logic                 retire;
    logic                 do_alloc;
    logic [ROB_DEPTH-1:0] wb_hit;

    assign retire   = (state[head] == ENTRY_DONE) && !squash;
    assign do_alloc = alloc.valid && !flush;

    // Pc tag match, only one issued entry can carry a given pc.
    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            wb_hit[i] = wb.valid && (state[i] == ENTRY_ISSUED) && (pc_mem[i] == wb.pc);
        end
    end

    always_comb begin
        count_next = count;
        if (do_alloc && !retire) begin
            count_next = count + 1'b1;
        end else if (retire && !do_alloc) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state[i] <= ENTRY_FREE;
            end
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            squash  <= 1'b0;
            ready_q <= 1'b1;
        end else begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (wb_hit[i]) begin
                    state[i] <= ENTRY_DONE;
                end
            end
            if (retire) begin
                state[head] <= ENTRY_FREE;
                head        <= head + 1'b1;
                squash      <= cmt.mispredict;   // Younger entries must not retire.
            end
            if (do_alloc) begin
                state[tail] <= ENTRY_ISSUED;
                tail        <= tail + 1'b1;
            end
            count   <= count_next;
            ready_q <= count_next < CNT_W'(ROB_DEPTH - ALLOC_MARGIN);
        end
    end

    // Entry payload.
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            pc_mem[tail]     <= alloc.pc;
            rd_mem[tail]     <= alloc.rd;
            target_mem[tail] <= alloc.pc + 32'd4;   // Assume fall-through until resolved.
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (wb_hit[i]) begin
                data_mem[i] <= wb.data;
                if (wb.src == SRC_ALU) begin
                    target_mem[i] <= wb.target;
                end
            end
        end
    end

    assign alloc.ready = ready_q;

    assign cmt.valid      = retire;
    assign cmt.pc         = pc_mem[head];
    assign cmt.rd         = rd_mem[head];
    assign cmt.data       = data_mem[head];
    assign cmt.target     = target_mem[head];
    assign cmt.mispredict = target_mem[head] != pc_mem[head] + 32'd4;

endmodule

//--- commit_stage.sv
module commit_stage import ooo_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    rob_commit_if.sink            cmt,
    output logic                  commit_valid,
    output logic [XLEN-1:0]       commit_pc,
    output logic [REG_ADDR_W-1:0] commit_rd,
    output logic [XLEN-1:0]       commit_data,
    output logic                  flush,
    output logic [XLEN-1:0]       redirect_pc,
    input  logic [REG_ADDR_W-1:0] rf_raddr,
    output logic [XLEN-1:0]       rf_rdata
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            commit_mispredict;
    logic [XLEN-1:0] commit_target;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            commit_valid <= cmt.valid;
            flush        <= commit_valid && commit_mispredict;   // One cycle after the commit.
        end
    end

    always_ff @(posedge clk) begin
        commit_pc         <= cmt.pc;
        commit_rd         <= cmt.rd;
        commit_data       <= cmt.data;
        commit_mispredict <= cmt.mispredict;
        commit_target     <= cmt.target;
        redirect_pc       <= commit_target;
    end

    // Architectural registers, written on the same edge as commit_valid rises.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (cmt.valid && (cmt.rd != '0)) begin
            regs[cmt.rd] <= cmt.data;   // x0 is never written.
        end
    end

    assign rf_rdata = regs[rf_raddr];

endmodule

//--- ooo_commit_top.sv
module ooo_commit_top import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dec_valid,
    input  logic [XLEN-1:0]       dec_pc,
    input  logic [REG_ADDR_W-1:0] dec_rd,
    input  logic                  alu_valid,
    input  logic [XLEN-1:0]       alu_pc,
    input  logic [XLEN-1:0]       alu_data,
    input  logic [XLEN-1:0]       alu_target,
    input  logic                  slb_valid,
    input  logic [XLEN-1:0]       slb_pc,
    input  logic [XLEN-1:0]       slb_data,
    input  logic [REG_ADDR_W-1:0] rf_raddr,
    output logic                  rob_ready,
    output logic                  commit_valid,
    output logic [XLEN-1:0]       commit_pc,
    output logic [REG_ADDR_W-1:0] commit_rd,
    output logic [XLEN-1:0]       commit_data,
    output logic                  flush,
    output logic [XLEN-1:0]       redirect_pc,
    output logic [XLEN-1:0]       rf_rdata
);

    rob_alloc_if  alloc_bus ();
    rob_wb_if     wb_bus ();
    rob_commit_if cmt_bus ();

    assign rob_ready = alloc_bus.ready;

    dispatch_stage u_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .dec_valid (dec_valid),
        .dec_pc    (dec_pc),
        .dec_rd    (dec_rd),
        .alloc     (alloc_bus.source)
    );

    completion_merge u_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .alu_valid  (alu_valid),
        .alu_pc     (alu_pc),
        .alu_data   (alu_data),
        .alu_target (alu_target),
        .slb_valid  (slb_valid),
        .slb_pc     (slb_pc),
        .slb_data   (slb_data),
        .wb         (wb_bus.source)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .alloc (alloc_bus.sink),
        .wb    (wb_bus.sink),
        .cmt   (cmt_bus.source)
    );

    commit_stage u_commit (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmt          (cmt_bus.sink),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .rf_raddr     (rf_raddr),
        .rf_rdata     (rf_rdata)
    );

endmodule

//--- tb_ooo_commit.sv
module tb_ooo_commit import ooo_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROB_DEPTH  = 16;
    localparam int WAIT_LIMIT = 64;

    logic                  clk;
    logic                  rst_n;
    logic                  dec_valid;
    logic [XLEN-1:0]       dec_pc;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic                  alu_valid;
    logic [XLEN-1:0]       alu_pc;
    logic [XLEN-1:0]       alu_data;
    logic [XLEN-1:0]       alu_target;
    logic                  slb_valid;
    logic [XLEN-1:0]       slb_pc;
    logic [XLEN-1:0]       slb_data;
    logic [REG_ADDR_W-1:0] rf_raddr;
    logic                  rob_ready;
    logic                  commit_valid;
    logic [XLEN-1:0]       commit_pc;
    logic [REG_ADDR_W-1:0] commit_rd;
    logic [XLEN-1:0]       commit_data;
    logic                  flush;
    logic [XLEN-1:0]       redirect_pc;
    logic [XLEN-1:0]       rf_rdata;

    // Program-order model of the instructions still expected to commit.
    logic [XLEN-1:0]       exp_pc     [$];
    logic [REG_ADDR_W-1:0] exp_rd     [$];
    logic [XLEN-1:0]       exp_data   [$];
    logic [XLEN-1:0]       exp_target [$];
    logic [XLEN-1:0]       ref_regs   [2**REG_ADDR_W];
    logic                  flush_due;
    logic [XLEN-1:0]       flush_target;
    logic [31:0]           lfsr_state;
    int                    commit_count;
    int                    flush_count;
    int                    mismatch_count;
    int                    failure_count;

    ooo_commit_top #(.ROB_DEPTH(ROB_DEPTH)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0d ns: %s got %h, expected %h", $time, name, got, exp);
        mismatch_count++;
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0d ns: %s", $time, what);
        failure_count++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                       // Drive point after the edge.
    endtask

    // Samples at the falling edge, where all registered outputs are settled.
    task automatic check_outputs();
        if (flush_due && !flush) begin
            report_failure("flush did not follow the mispredicted commit");
        end else if (flush_due && redirect_pc !== flush_target) begin
            report_mismatch("redirect_pc", redirect_pc, flush_target);
        end else if (!flush_due && flush) begin
            report_failure("flush raised without a mispredicted commit");
        end
        flush_due = 1'b0;
        if (flush) begin
            flush_count++;
        end
        if (commit_valid && exp_pc.size() == 0) begin
            report_failure("commit with no instruction outstanding");
        end else if (commit_valid) begin
            if (commit_pc !== exp_pc[0])
                report_mismatch("commit_pc", commit_pc, exp_pc[0]);
            if (commit_rd !== exp_rd[0])
                report_mismatch("commit_rd", 32'(commit_rd), 32'(exp_rd[0]));
            if (commit_data !== exp_data[0])
                report_mismatch("commit_data", commit_data, exp_data[0]);
            commit_count++;
            if (exp_rd[0] != '0) begin
                ref_regs[exp_rd[0]] = exp_data[0];
            end
            if (exp_target[0] != exp_pc[0] + 32'd4) begin
                flush_due    = 1'b1;
                flush_target = exp_target[0];
                exp_pc.delete();  // Younger instructions are squashed.
                exp_rd.delete();
                exp_data.delete();
                exp_target.delete();
            end else begin
                void'(exp_pc.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                void'(exp_target.pop_front());
            end
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (rst_n) begin
                check_outputs();
            end
        end
    end

    task automatic wait_for_ready();
        int n;
        n = 0;
        while (!rob_ready && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!rob_ready) begin
            report_failure("timeout waiting for rob_ready");
        end
    endtask

    task automatic wait_for_drain();
        int n;
        n = 0;
        while (exp_pc.size() != 0 && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (exp_pc.size() != 0) begin
            report_failure("timeout waiting for outstanding commits");
        end
    endtask

    task automatic dispatch_instr(input logic [XLEN-1:0] pc, input logic [REG_ADDR_W-1:0] rd,
                                  input logic [XLEN-1:0] data, input logic [XLEN-1:0] target);
        wait_for_ready();
        dec_valid = 1'b1;
        dec_pc    = pc;
        dec_rd    = rd;
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        exp_target.push_back(target);
        next_cycle();
        dec_valid = 1'b0;
    endtask

    task automatic complete_alu(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] data,
                                input logic [XLEN-1:0] target);
        alu_valid  = 1'b1;
        alu_pc     = pc;
        alu_data   = data;
        alu_target = target;
        next_cycle();
        alu_valid = 1'b0;
    endtask

    task automatic check_reg(input logic [REG_ADDR_W-1:0] r);
        rf_raddr = r;
        @(negedge clk);
        if (rf_rdata !== ref_regs[r])
            report_mismatch($sformatf("rf_rdata[x%0d]", r), rf_rdata, ref_regs[r]);
        next_cycle();
    endtask

    task automatic test_reset_state();
        if (rob_ready !== 1'b1)
            report_mismatch("rob_ready", 32'(rob_ready), 32'd1);
        if (commit_valid !== 1'b0)
            report_mismatch("commit_valid", 32'(commit_valid), 32'd0);
        if (flush !== 1'b0)
            report_mismatch("flush", 32'(flush), 32'd0);
        check_reg(REG_ADDR_W'(rand_bits(REG_ADDR_W)));
    endtask

    task automatic test_reverse_completion();
        logic [XLEN-1:0]       pc   [4];
        logic [XLEN-1:0]       data [4];
        logic [REG_ADDR_W-1:0] rd   [4];
        rd = '{5'd1, 5'd2, 5'd0, 5'd3};
        for (int i = 0; i < 4; i++) begin
            pc[i]   = 32'h0000_1000 + 32'(4 * i);
            data[i] = rand_bits(32);
            dispatch_instr(pc[i], rd[i], data[i], pc[i] + 32'd4);
        end
        for (int i = 3; i >= 0; i--) begin
            complete_alu(pc[i], data[i], pc[i] + 32'd4);
        end
        wait_for_drain();
        for (int i = 0; i < 4; i++) begin
            check_reg(REG_ADDR_W'(i));
        end
    endtask

    task automatic test_same_cycle_results();
        logic [XLEN-1:0] d0;
        logic [XLEN-1:0] d1;
        d0 = rand_bits(32);
        d1 = rand_bits(32);
        dispatch_instr(32'h0000_1100, 5'd4, d0, 32'h0000_1104);
        dispatch_instr(32'h0000_1104, 5'd5, d1, 32'h0000_1108);
        alu_valid  = 1'b1;         // Younger via ALU, so the older result gets parked.
        alu_pc     = 32'h0000_1104;
        alu_data   = d1;
        alu_target = 32'h0000_1108;
        slb_valid  = 1'b1;
        slb_pc     = 32'h0000_1100;
        slb_data   = d0;
        next_cycle();
        alu_valid = 1'b0;
        slb_valid = 1'b0;
        wait_for_drain();
        check_reg(5'd4);
        check_reg(5'd5);
    endtask

    task automatic test_mispredict_flush();
        logic [XLEN-1:0] d [3];
        int              c0;
        int              f0;
        int              n;
        c0 = commit_count;
        f0 = flush_count;
        for (int i = 0; i < 3; i++) begin
            d[i] = rand_bits(32);
        end
        dispatch_instr(32'h0000_2000, 5'd6, d[0], 32'h0000_4000);
        dispatch_instr(32'h0000_2004, 5'd1, d[1], 32'h0000_2008);
        dispatch_instr(32'h0000_2008, 5'd2, d[2], 32'h0000_200c);
        complete_alu(32'h0000_2000, d[0], 32'h0000_4000);
        complete_alu(32'h0000_2004, d[1], 32'h0000_2008);
        complete_alu(32'h0000_2008, d[2], 32'h0000_200c);
        n = 0;
        while (flush_count == f0 && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (flush_count == f0) begin
            report_failure("timeout waiting for flush after mispredict");
        end
        repeat (6) next_cycle();   // Any late commit of a squashed entry shows up here.
        if (commit_count - c0 != 1)
            report_mismatch("commits before flush", 32'(commit_count - c0), 32'd1);
        check_reg(5'd6);
        check_reg(5'd1);
        check_reg(5'd2);
        d[0] = rand_bits(32);
        dispatch_instr(32'h0000_4000, 5'd7, d[0], 32'h0000_4004);
        complete_alu(32'h0000_4000, d[0], 32'h0000_4004);
        wait_for_drain();
        check_reg(5'd7);
    endtask

    task automatic test_ready_backpressure();
        logic [XLEN-1:0] data [ROB_DEPTH];
        int              n;
        n = 0;
        while (rob_ready && n < ROB_DEPTH) begin
            data[n] = rand_bits(32);
            dispatch_instr(32'h0000_3000 + 32'(4 * n), REG_ADDR_W'(8 + n), data[n],
                           32'h0000_3004 + 32'(4 * n));
            next_cycle();          // Ready trails the allocation by one cycle.
            n++;
        end
        if (rob_ready) begin
            report_failure("rob_ready never dropped with no completions");
        end else if (n < ROB_DEPTH - ALLOC_MARGIN - 1 || n > ROB_DEPTH - ALLOC_MARGIN + 1) begin
            report_mismatch("outstanding at ready drop", 32'(n), 32'(ROB_DEPTH - ALLOC_MARGIN));
        end
        complete_alu(32'h0000_3000, data[0], 32'h0000_3004);
        wait_for_ready();
        for (int i = 1; i < n; i++) begin
            complete_alu(32'h0000_3000 + 32'(4 * i), data[i], 32'h0000_3004 + 32'(4 * i));
        end
        wait_for_drain();
    endtask

    initial begin
        lfsr_state     = 32'hb027f924;
        flush_due      = 1'b0;
        flush_target   = '0;
        commit_count   = 0;
        flush_count    = 0;
        mismatch_count = 0;
        failure_count  = 0;
        for (int i = 0; i < 2**REG_ADDR_W; i++) begin
            ref_regs[i] = '0;
        end
        rst_n      = 1'b0;
        dec_valid  = 1'b0;
        dec_pc     = '0;
        dec_rd     = '0;
        alu_valid  = 1'b0;
        alu_pc     = '0;
        alu_data   = '0;
        alu_target = '0;
        slb_valid  = 1'b0;
        slb_pc     = '0;
        slb_data   = '0;
        rf_raddr   = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        test_reset_state();
        test_reverse_completion();
        test_same_cycle_results();
        test_mispredict_flush();
        test_ready_backpressure();
        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count + failure_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- compile.f
ooo_pkg.sv
ooo_if.sv
dispatch_stage.sv
completion_merge.sv
reorder_buffer.sv
commit_stage.sv
ooo_commit_top.sv
tb_ooo_commit.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_ooo_commit \
    -f compile.f -o tb_ooo_commit \
    && ./obj_dir/tb_ooo_commit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
